// ==== bench/hazardTests.txt ====
# instr(hex) mduBusy stall fwdDecodeRs fwdDecodeRt fwdExecuteRs fwdExecuteRt
# selects: 0 none, 1 execute, 2 memory, 3 writeback; one line per cycle
00000000 0 0 0 0 0 0   # nop after reset
00000000 0 0 0 0 0 0
00221821 0 0 0 0 0 0   # addu $3,$1,$2
00652021 0 0 0 0 0 0   # addu $4,$3,$5
00433021 0 0 0 2 2 0   # addu $6,$2,$3
00000000 0 0 0 0 0 3
00000000 0 0 0 0 0 0
8C280000 0 0 0 0 0 0   # lw $8,0($1)
11090000 0 1 0 0 0 0   # beq $8,$9 held
11090000 0 1 0 0 0 0
11090000 0 0 3 0 0 0
8C4A0004 0 0 0 0 0 0   # lw $10,4($2)
01415821 0 1 0 0 0 0   # addu $11,$10,$1 held
01415821 0 0 0 0 0 0
00000000 0 0 0 0 3 0
00000000 0 0 0 0 0 0
8C2C0000 0 0 0 0 0 0   # lw $12,0($1)
AC4C0000 0 0 0 0 0 0   # sw $12,0($2)
358D0005 0 0 0 0 0 0   # ori $13,$12,5
00000000 0 0 0 0 3 0
00000000 0 0 0 0 0 0
0C000010 0 0 0 0 0 0   # jal
03E00008 0 0 1 0 0 0   # jr $31
00000000 0 0 0 0 2 0
00000000 0 0 0 0 0 0
8C200000 0 0 0 0 0 0   # lw $0,0($1)
10000000 0 0 0 0 0 0   # beq $0,$0
00220018 1 1 0 0 0 0   # mult $1,$2 while busy
00220018 0 0 0 0 0 0
00003812 0 1 0 0 0 0   # mflo $7 behind mult
00003812 1 1 0 0 0 0
00003812 0 0 0 0 0 0
00221821 1 0 0 0 0 0   # addu ignores busy
00E32021 1 0 2 0 0 0   # addu $4,$7,$3
00000000 0 0 0 0 3 2
00000000 0 0 0 0 0 0
3C091234 0 0 0 0 0 0   # lui $9
35295678 0 0 1 0 0 0   # ori $9,$9
00000000 0 0 0 0 2 0
00000000 0 0 0 0 0 0

// ==== bench/hazardUnitBench.sv ====
module hazardUnitBench;
	timeunit 1ns;
	timeprecision 1ps;

	import hazardPkg::*;

	localparam int clkPeriod     = 40;
	localparam int driveDelay    = 2;
	localparam int sampleLead    = 2;
	localparam int resetCycles   = 8;
	localparam string testFile   = "bench/hazardTests.txt";

	// DUT ports
	logic     clk;
	logic     reset;
	instrWord instr;
	logic     mduBusy;
	logic     stall;
	fwdSel    fwdDecodeRs;
	fwdSel    fwdDecodeRt;
	fwdSel    fwdExecuteRs;
	fwdSel    fwdExecuteRt;

	// One entry per test cycle
	int          testLine[$];
	logic [31:0] testInstr[$];
	logic        testBusy[$];
	logic        expStall[$];
	fwdSel       expDecodeRs[$];
	fwdSel       expDecodeRt[$];
	fwdSel       expExecuteRs[$];
	fwdSel       expExecuteRt[$];

	int   stallErrors = 0;
	int   fwdErrors   = 0;
	int   fileErrors  = 0;
	int   cycleCount  = 0;
	int   cycleLimit  = 0;
	logic limitReady  = 1'b0;

	hazardUnit hazardUnit_inst (
		.clk(clk), .reset(reset), .instr(instr), .mduBusy(mduBusy), .stall(stall),
		.fwdDecodeRs(fwdDecodeRs), .fwdDecodeRt(fwdDecodeRt),
		.fwdExecuteRs(fwdExecuteRs), .fwdExecuteRt(fwdExecuteRt));

	always #(clkPeriod / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Test file loading
	//////////////////////////////////////////////////////////////////////

	task automatic loadTests();
		int          fd;
		int          lineNo;
		int          fields;
		string       line;
		logic [31:0] word;
		int          busy;
		int          stallBit;
		int          dRs;
		int          dRt;
		int          eRs;
		int          eRt;
		fd = $fopen(testFile, "r");
		if (fd == 0)
		begin
			$display("Cannot open the test file %s", testFile);
			fileErrors++;
			return;
		end
		lineNo = 0;
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			lineNo++;
			// Blank lines and comments
			if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
				continue;
			fields = $sscanf(line, "%h %d %d %d %d %d %d", word, busy, stallBit,
				dRs, dRt, eRs, eRt);
			if (fields != 7 || busy > 1 || stallBit > 1 || dRs > 3 || dRt > 3 ||
				eRs > 3 || eRt > 3)
			begin
				$display("Line %0d of %s is malformed and was skipped", lineNo, testFile);
				fileErrors++;
				continue;
			end
			testLine.push_back(lineNo);
			testInstr.push_back(word);
			testBusy.push_back(busy[0]);
			expStall.push_back(stallBit[0]);
			expDecodeRs.push_back(fwdSel'(dRs[1:0]));
			expDecodeRt.push_back(fwdSel'(dRt[1:0]));
			expExecuteRs.push_back(fwdSel'(eRs[1:0]));
			expExecuteRt.push_back(fwdSel'(eRt[1:0]));
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic checkStall(int lineNo, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0d ns, line %0d: stall expected %b actual %b",
				$time, lineNo, expected, actual);
			stallErrors++;
		end
	endtask

	task automatic checkFwd(int lineNo, string name, fwdSel expected, fwdSel actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0d ns, line %0d: %s expected %s actual %s (%b)",
				$time, lineNo, name, expected.name(), actual.name(), actual);
			fwdErrors++;
		end
	endtask

	// Guard against a stuck run
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (limitReady && cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run went past %0d cycles", cycleLimit);
			$display(">>> FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checking
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		instr = '0;
		mduBusy = 1'b0;
		loadTests();
		if (testInstr.size() == 0 && fileErrors == 0)
		begin
			$display("No test lines found in %s", testFile);
			fileErrors++;
		end
		// Lines plus reset plus slack
		cycleLimit = testInstr.size() + resetCycles + 20;
		limitReady = 1'b1;

		repeat (resetCycles) @(posedge clk);
		#(driveDelay);
		reset = 1'b0;

		for (int i = 0; i < testInstr.size(); i++)
		begin
			instr = testInstr[i];
			mduBusy = testBusy[i];
			// Sample just ahead of the next edge
			#(clkPeriod - driveDelay - sampleLead);
			checkStall(testLine[i], expStall[i], stall);
			checkFwd(testLine[i], "fwdDecodeRs", expDecodeRs[i], fwdDecodeRs);
			checkFwd(testLine[i], "fwdDecodeRt", expDecodeRt[i], fwdDecodeRt);
			checkFwd(testLine[i], "fwdExecuteRs", expExecuteRs[i], fwdExecuteRs);
			checkFwd(testLine[i], "fwdExecuteRt", expExecuteRt[i], fwdExecuteRt);
			@(posedge clk);
			#(driveDelay);
		end

		$display("Errors: stall %0d, forward %0d, test file %0d",
			stallErrors, fwdErrors, fileErrors);
		if (stallErrors + fwdErrors + fileErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== design/accessTimeDecoder.sv ====
module accessTimeDecoder
(
	input  hazardPkg::instrWord instr,
	output hazardPkg::regAddr   readAddr1,
	output hazardPkg::timeCode  readTime1,
	output hazardPkg::regAddr   readAddr2,
	output hazardPkg::timeCode  readTime2,
	output hazardPkg::regAddr   writeAddr,
	output hazardPkg::timeCode  writeTime,
	output logic                mduReq
);
	import hazardPkg::*;

	// Raw destination before the register zero filter
	regAddr  destAddr;
	timeCode destTime;

	//////////////////////////////////////////////////////////////////////
	// Read slots, write slot and MDU request per opcode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Unsupported words decode to no hazard
		readAddr1 = '0;
		readTime1 = '0;
		readAddr2 = '0;
		readTime2 = '0;
		destAddr  = '0;
		destTime  = '0;
		mduReq    = 1'b0;

		case (instr.r.opcode)
			opSpecial:
			begin
				// R-type with destination in rd
				case (instr.r.funct)
					fnAddu, fnSubu:
					begin
						readAddr1 = instr.r.rs;
						readTime1 = 2'd1;
						readAddr2 = instr.r.rt;
						readTime2 = 2'd1;
						destAddr  = instr.r.rd;
						destTime  = 2'd2;
					end
					fnSll:
					begin
						// Shift source only in rt
						readAddr2 = instr.r.rt;
						readTime2 = 2'd1;
						destAddr  = instr.r.rd;
						destTime  = 2'd2;
					end
					fnMult:
					begin
						// Result goes to hi/lo instead of the register file
						readAddr1 = instr.r.rs;
						readTime1 = 2'd1;
						readAddr2 = instr.r.rt;
						readTime2 = 2'd1;
						mduReq    = 1'b1;
					end
					fnMflo, fnMfhi:
					begin
						destAddr = instr.r.rd;
						destTime = 2'd2;
						mduReq   = 1'b1;
					end
					fnJr:
					begin
						// Target needed in decode
						readAddr1 = instr.r.rs;
						readTime1 = 2'd0;
					end
					default:
					begin
					end
				endcase
			end
			opOri:
			begin
				// I-type with destination in rt
				readAddr1 = instr.i.rs;
				readTime1 = 2'd1;
				destAddr  = instr.i.rt;
				destTime  = 2'd2;
			end
			opLui:
			begin
				destAddr = instr.i.rt;
				destTime = 2'd1;
			end
			opLw:
			begin
				// Base in execute and data after memory
				readAddr1 = instr.i.rs;
				readTime1 = 2'd1;
				destAddr  = instr.i.rt;
				destTime  = 2'd3;
			end
			opSw:
			begin
				// Store data not needed until memory
				readAddr1 = instr.i.rs;
				readTime1 = 2'd1;
				readAddr2 = instr.i.rt;
				readTime2 = 2'd2;
			end
			opBeq:
			begin
				// Compare in decode
				readAddr1 = instr.i.rs;
				readTime1 = 2'd0;
				readAddr2 = instr.i.rt;
				readTime2 = 2'd0;
			end
			opJal:
			begin
				destAddr = regRa;
				destTime = 2'd1;
			end
			default:
			begin
				// opJ and the rest touch no register
			end
		endcase
	end

	// A write to register zero carries no timing
	assign writeAddr = destAddr;
	assign writeTime = (destAddr == '0) ? '0 : destTime;

endmodule

// ==== design/forwardSelect.sv ====
module forwardSelect
(
	input  hazardPkg::regAddr  readAddr1,
	input  hazardPkg::regAddr  readAddr2,
	input  hazardPkg::regAddr  execRead1,
	input  hazardPkg::regAddr  execRead2,
	input  hazardPkg::regAddr  execWrite,
	input  hazardPkg::timeCode execTime,
	input  hazardPkg::regAddr  memWrite,
	input  hazardPkg::timeCode memTime,
	input  hazardPkg::regAddr  wbWrite,
	output hazardPkg::fwdSel   fwdDecodeRs,
	output hazardPkg::fwdSel   fwdDecodeRt,
	output hazardPkg::fwdSel   fwdExecuteRs,
	output hazardPkg::fwdSel   fwdExecuteRt
);
	import hazardPkg::*;

	// Result already computed in that stage
	logic execReady;
	logic memReady;

	assign execReady = (execTime < 2'd2);
	assign memReady  = (memTime < 2'd2);

	//////////////////////////////////////////////////////////////////////
	// Nearest matching producer
	//////////////////////////////////////////////////////////////////////

	// Execute is skipped for operands already in execute
	function automatic fwdSel nearestSource(
		regAddr addr,
		logic   withExec,
		regAddr eWrite,
		logic   eReady,
		regAddr mWrite,
		logic   mReady,
		regAddr wWrite
	);
		fwdSel pick;
		pick = fwdNone;
		// Register zero is never forwarded
		if (addr != '0)
		begin
			if (withExec && addr == eWrite)
				pick = eReady ? fwdExecute : fwdNone;
			else if (addr == mWrite)
				pick = mReady ? fwdMemory : fwdNone;
			else if (addr == wWrite)
				pick = fwdWriteback;
		end
		return pick;
	endfunction

	// Decode operands
	assign fwdDecodeRs = nearestSource(readAddr1, 1'b1, execWrite, execReady,
		memWrite, memReady, wbWrite);
	assign fwdDecodeRt = nearestSource(readAddr2, 1'b1, execWrite, execReady,
		memWrite, memReady, wbWrite);

	// Execute operands
	assign fwdExecuteRs = nearestSource(execRead1, 1'b0, execWrite, execReady,
		memWrite, memReady, wbWrite);
	assign fwdExecuteRt = nearestSource(execRead2, 1'b0, execWrite, execReady,
		memWrite, memReady, wbWrite);

endmodule

// ==== design/hazardPkg.sv ====
package hazardPkg;

	//////////////////////////////////////////////////////////////////////
	// MIPS field codes
	//////////////////////////////////////////////////////////////////////

	// Primary opcodes
	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opJ       = 6'b000010;
	localparam logic [5:0] opJal     = 6'b000011;
	localparam logic [5:0] opBeq     = 6'b000100;
	localparam logic [5:0] opOri     = 6'b001101;
	localparam logic [5:0] opLui     = 6'b001111;
	localparam logic [5:0] opLw      = 6'b100011;
	localparam logic [5:0] opSw      = 6'b101011;

	// Function codes under opSpecial
	localparam logic [5:0] fnSll  = 6'b000000;
	localparam logic [5:0] fnJr   = 6'b001000;
	localparam logic [5:0] fnMfhi = 6'b010000;
	localparam logic [5:0] fnMflo = 6'b010010;
	localparam logic [5:0] fnMult = 6'b011000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSubu = 6'b100011;

	//////////////////////////////////////////////////////////////////////
	// Register and timing types
	//////////////////////////////////////////////////////////////////////

	// Register number, zero means no register
	typedef logic [4:0] regAddr;

	// Link register written by jal
	localparam regAddr regRa = 5'd31;

	// Tuse or Tnew in cycles
	typedef logic [1:0] timeCode;

	//////////////////////////////////////////////////////////////////////
	// Instruction views
	//////////////////////////////////////////////////////////////////////

	// R-type layout
	typedef struct packed {
		logic [5:0] opcode;
		regAddr     rs;
		regAddr     rt;
		regAddr     rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields;

	// I-type layout
	typedef struct packed {
		logic [5:0]  opcode;
		regAddr      rs;
		regAddr      rt;
		logic [15:0] imm;
	} iFields;

	// One word, two decodings
	typedef union packed {
		rFields r;
		iFields i;
	} instrWord;

	// Forwarding source, named by the stage the producer sits in
	typedef enum logic [1:0] {
		fwdNone      = 2'd0,
		fwdExecute   = 2'd1,
		fwdMemory    = 2'd2,
		fwdWriteback = 2'd3
	} fwdSel;

endpackage

// ==== design/hazardUnit.sv ====
module hazardUnit
(
	input  logic                clk,
	input  logic                reset,
	input  hazardPkg::instrWord instr,
	input  logic                mduBusy,
	output logic                stall,
	output hazardPkg::fwdSel    fwdDecodeRs,
	output hazardPkg::fwdSel    fwdDecodeRt,
	output hazardPkg::fwdSel    fwdExecuteRs,
	output hazardPkg::fwdSel    fwdExecuteRt
);
	import hazardPkg::*;

	// Decode-stage access timing
	regAddr  readAddr1;
	regAddr  readAddr2;
	regAddr  writeAddr;
	timeCode readTime1;
	timeCode readTime2;
	timeCode writeTime;
	logic    mduReq;

	// Tracked later stages
	regAddr  execRead1;
	regAddr  execRead2;
	regAddr  execWrite;
	regAddr  memWrite;
	regAddr  wbWrite;
	timeCode execTime;
	timeCode memTime;
	logic    execMdu;

	accessTimeDecoder accessTimeDecoder_inst (
		.instr(instr), .readAddr1(readAddr1), .readTime1(readTime1),
		.readAddr2(readAddr2), .readTime2(readTime2), .writeAddr(writeAddr),
		.writeTime(writeTime), .mduReq(mduReq));

	stageTracker stageTracker_inst (
		.clk(clk), .reset(reset), .stall(stall), .readAddr1(readAddr1),
		.readAddr2(readAddr2), .writeAddr(writeAddr), .writeTime(writeTime),
		.mduReq(mduReq), .execRead1(execRead1), .execRead2(execRead2),
		.execWrite(execWrite), .execTime(execTime), .execMdu(execMdu),
		.memWrite(memWrite), .memTime(memTime), .wbWrite(wbWrite));

	stallControl stallControl_inst (
		.readAddr1(readAddr1), .readTime1(readTime1), .readAddr2(readAddr2),
		.readTime2(readTime2), .mduReq(mduReq), .execMdu(execMdu),
		.mduBusy(mduBusy), .execWrite(execWrite), .execTime(execTime),
		.memWrite(memWrite), .memTime(memTime), .stall(stall));

	forwardSelect forwardSelect_inst (
		.readAddr1(readAddr1), .readAddr2(readAddr2), .execRead1(execRead1),
		.execRead2(execRead2), .execWrite(execWrite), .execTime(execTime),
		.memWrite(memWrite), .memTime(memTime), .wbWrite(wbWrite),
		.fwdDecodeRs(fwdDecodeRs), .fwdDecodeRt(fwdDecodeRt),
		.fwdExecuteRs(fwdExecuteRs), .fwdExecuteRt(fwdExecuteRt));

endmodule

// ==== design/stageTracker.sv ====
module stageTracker
(
	input  logic               clk,
	input  logic               reset,
	input  logic               stall,
	input  hazardPkg::regAddr  readAddr1,
	input  hazardPkg::regAddr  readAddr2,
	input  hazardPkg::regAddr  writeAddr,
	input  hazardPkg::timeCode writeTime,
	input  logic               mduReq,
	output hazardPkg::regAddr  execRead1,
	output hazardPkg::regAddr  execRead2,
	output hazardPkg::regAddr  execWrite,
	output hazardPkg::timeCode execTime,
	output logic               execMdu,
	output hazardPkg::regAddr  memWrite,
	output hazardPkg::timeCode memTime,
	output hazardPkg::regAddr  wbWrite
);
	import hazardPkg::*;

	// One cycle less to wait with a floor at zero
	function automatic timeCode ageTime(timeCode t);
		return (t == '0) ? '0 : t - 2'd1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Execute, memory and writeback stage registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			execRead1 <= '0;
			execRead2 <= '0;
			execWrite <= '0;
			execTime  <= '0;
			execMdu   <= 1'b0;
			memWrite  <= '0;
			memTime   <= '0;
			wbWrite   <= '0;
		end
		else
		begin
			// Decode held outside while execute gets a bubble
			if (stall)
			begin
				execRead1 <= '0;
				execRead2 <= '0;
				execWrite <= '0;
				execTime  <= '0;
				execMdu   <= 1'b0;
			end
			else
			begin
				execRead1 <= readAddr1;
				execRead2 <= readAddr2;
				execWrite <= writeAddr;
				execTime  <= writeTime;
				execMdu   <= mduReq;
			end

			// Later stages always drain
			memWrite <= execWrite;
			memTime  <= ageTime(execTime);

			// Writeback result exists by definition
			wbWrite <= memWrite;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Empty slots stay timeless across both tracked stages
	assert property (@(posedge clk) disable iff (reset)
		(execWrite != '0 || execTime == '0) && (memWrite != '0 || memTime == '0))
	else $error("stage holds time without a write address");

endmodule

// ==== design/stallControl.sv ====
module stallControl
(
	input  hazardPkg::regAddr  readAddr1,
	input  hazardPkg::timeCode readTime1,
	input  hazardPkg::regAddr  readAddr2,
	input  hazardPkg::timeCode readTime2,
	input  logic               mduReq,
	input  logic               execMdu,
	input  logic               mduBusy,
	input  hazardPkg::regAddr  execWrite,
	input  hazardPkg::timeCode execTime,
	input  hazardPkg::regAddr  memWrite,
	input  hazardPkg::timeCode memTime,
	output logic               stall
);
	import hazardPkg::*;

	// Cycles still missing before each tracked result exists
	timeCode execLeft;
	timeCode memLeft;

	// Per-cause stall terms
	logic hazard1;
	logic hazard2;
	logic mduHazard;

	//////////////////////////////////////////////////////////////////////
	// Tnew against Tuse
	//////////////////////////////////////////////////////////////////////

	// One cycle of the count is spent inside each stage
	assign execLeft = (execTime == '0) ? '0 : execTime - 2'd1;
	assign memLeft  = (memTime == '0) ? '0 : memTime - 2'd1;

	// First operand
	assign hazard1 = (readAddr1 != '0) &&
		(((readAddr1 == execWrite) && (execLeft > readTime1)) ||
		((readAddr1 == memWrite) && (memLeft > readTime1)));

	// Second operand
	assign hazard2 = (readAddr2 != '0) &&
		(((readAddr2 == execWrite) && (execLeft > readTime2)) ||
		((readAddr2 == memWrite) && (memLeft > readTime2)));

	// Multiplier busy or just being started by the instruction ahead
	assign mduHazard = mduReq && (mduBusy || execMdu);

	assign stall = hazard1 || hazard2 || mduHazard;

endmodule

// ==== filelist.f ====
design/hazardPkg.sv
design/accessTimeDecoder.sv
design/stageTracker.sv
design/stallControl.sv
design/forwardSelect.sv
design/hazardUnit.sv
bench/hazardUnitBench.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the hazard unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f filelist.f --top-module hazardUnitBench \
	-Mdir obj_dir -o hazardSim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/hazardSim > sim.log 2>&1
cat sim.log

# Verdict from the simulation log
grep -q '>>> FAIL' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '>>> PASS' sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
exit 0
